// ==== files.f ====
cpu_types_pkg.sv
control_unit.sv
register_file.sv
pipe_latch.sv
decode_stage.sv
decode_top.sv
decode_chk.sv
decode_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= decode_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || { echo "Pass message missing from $(LOG)"; exit 1; }
	@! grep -qF "%Error" $(LOG) || { echo "Assertion error found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== decode_tb.sv ====
// Top-level testbench for decode_top with register preload, directed opcodes and random stalls
bind decode_top decode_chk chk0 (
  .CLK         (CLK),
  .rst         (rst),
  .fetch_valid (fetch_valid),
  .fetch       (fetch),
  .stall       (stall),
  .flush       (flush),
  .wb          (wb),
  .dec_valid   (dec_valid),
  .dec         (dec)
);

module decode_tb import cpu_types_pkg::*; ();

  localparam int N_RAND      = 300;
  localparam int STIM_CYCLES = 4 + 33 + 60 + N_RAND + 10;
  localparam int LIMIT       = STIM_CYCLES + 100;

  logic        CLK;
  logic        rst;
  logic        fetch_valid;
  fetch_pkt_t  fetch;
  logic        stall;
  logic        flush;
  wb_t         wb;
  logic        dec_valid;
  decode_pkt_t dec;

  word_t  pc_next;
  int     valid_count;
  int     timeouts;
  int     missing_valid;

  funct_t  functs [13] = '{ADD, ADDU, SUB, SUBU, AND, OR, XOR, NOR, SLT, SLTU, SLL, SRL, JR};
  opcode_t iops [12] = '{ADDI, ADDIU, SLTI, SLTIU, ANDI, ORI, XORI, LUI, LW, SW, BEQ, BNE};

  decode_top dut0 (.*);

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  function automatic regbits_t rand_reg();
    word_t r;
    r = $urandom;
    return r[4:0];
  endfunction

  function automatic word_t mk_r(funct_t fn, regbits_t rs, regbits_t rt, regbits_t rd);
    word_t r;
    r = $urandom;
    return {RTYPE, rs, rt, rd, r[4:0], fn};
  endfunction

  function automatic word_t mk_i(opcode_t op, regbits_t rs, regbits_t rt, logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // One instruction per edge plus an optional write-back request
  task automatic issue(input word_t instr, input wb_t wr);
    @(posedge CLK);
    fetch_valid <= 1'b1;
    fetch       <= '{instr: instr, pc: pc_next};
    wb          <= wr;
    pc_next = pc_next + 32'd4;
  endtask

  always @(posedge CLK) begin
    if (!rst && dec_valid)
      valid_count <= valid_count + 1;
  end

  initial begin
    #(LIMIT * 8);
    timeouts = timeouts + 1;
    $display("Run timed out after %0d cycles without finishing the stimulus", LIMIT);
    $display("summary: timeouts=%0d missing_valid=%0d assert_fails=%0d",
             timeouts, missing_valid, dut0.chk0.fail_count);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    word_t r;
    regbits_t sel;
    void'($urandom(94430));
    rst = 1'b1;
    fetch_valid = 1'b0;
    fetch = '0;
    stall = 1'b0;
    flush = 1'b0;
    wb = '0;
    pc_next = 32'h0000_1000;
    valid_count = 0;
    timeouts = 0;
    missing_valid = 0;
    repeat (4) @(posedge CLK);
    rst <= 1'b0;

    // Preload every register and try a write to $zero
    for (int i = 0; i < 32; i++) begin
      @(posedge CLK);
      r = $urandom;
      wb <= '{wen: 1'b1, wsel: 5'(i), wdat: r};
    end
    @(posedge CLK);
    wb <= '0;

    foreach (functs[i])
      issue(mk_r(functs[i], rand_reg(), rand_reg(), rand_reg()), '0);
    issue(mk_r(ADD, 5'd0, rand_reg(), rand_reg()), '0);
    foreach (iops[i]) begin
      issue(mk_i(iops[i], rand_reg(), rand_reg(), 16'hfff0), '0);
      issue(mk_i(iops[i], rand_reg(), rand_reg(), 16'h0123), '0);
    end
    r = $urandom;
    issue({J, r[25:0]}, '0);
    r = $urandom;
    issue({JAL, r[25:0]}, '0);
    issue({HALT, 26'h0}, '0);
    issue({6'h3e, 26'h155_5555}, '0);

    // Write rs while the instruction sits in decode
    sel = 5'd7;
    issue(mk_r(SUB, sel, 5'd9, 5'd3), '0);
    issue(mk_r(ADD, 5'd1, 5'd2, 5'd4), '{wen: 1'b1, wsel: sel, wdat: 32'hcafe_0001});

    for (int n = 0; n < N_RAND; n++) begin
      @(posedge CLK);
      r = $urandom;
      if (r[0])
        r = mk_i(iops[$urandom % 12], rand_reg(), rand_reg(), r[31:16]);
      fetch_valid <= ($urandom % 4) != 0;
      fetch       <= '{instr: r, pc: pc_next};
      stall       <= ($urandom % 8) == 0;
      flush       <= ($urandom % 10) == 0;
      r = $urandom;
      wb          <= '{wen: r[0], wsel: rand_reg(), wdat: $urandom};
      pc_next = pc_next + 32'd4;
    end
    @(posedge CLK);
    fetch_valid <= 1'b0;
    stall <= 1'b0;
    flush <= 1'b0;
    wb <= '0;
    repeat (5) @(posedge CLK);

    if (valid_count == 0) begin
      missing_valid = missing_valid + 1;
      $display("dec_valid never went high during the run");
    end
    $display("summary: timeouts=%0d missing_valid=%0d assert_fails=%0d",
             timeouts, missing_valid, dut0.chk0.fail_count);
    if (timeouts == 0 && missing_valid == 0 && dut0.chk0.fail_count == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// ==== decode_chk.sv ====
// Checker bound into decode_top that predicts dec from shadow registers and a two-deep pipe model
module decode_chk import cpu_types_pkg::*; (
  input logic        CLK,
  input logic        rst,
  input logic        fetch_valid,
  input fetch_pkt_t  fetch,
  input logic        stall,
  input logic        flush,
  input wb_t         wb,
  input logic        dec_valid,
  input decode_pkt_t dec
);

  word_t       shadow [0:31];
  fetch_pkt_t  s1;
  logic        s1_valid;
  decode_pkt_t pred;
  decode_pkt_t exp_pkt;
  logic        exp_valid;
  int          fail_count = 0;

  // Control fields straight from the opcode table
  function automatic ctrl_t expect_ctrl(word_t w);
    ctrl_t c;
    c        = '0;
    c.alu_op = ALU_ADD;
    c.pc_src = PC_SEQ;
    case (w[31:26])
      RTYPE: begin
        c.reg_dst = 1'b1;
        c.reg_wr  = 1'b1;
        case (w[5:0])
          ADD, ADDU: c.alu_op = ALU_ADD;
          SUB, SUBU: c.alu_op = ALU_SUB;
          AND:       c.alu_op = ALU_AND;
          OR:        c.alu_op = ALU_OR;
          XOR:       c.alu_op = ALU_XOR;
          NOR:       c.alu_op = ALU_NOR;
          SLT:       c.alu_op = ALU_SLT;
          SLTU:      c.alu_op = ALU_SLTU;
          SLL:       c.alu_op = ALU_SLL;
          SRL:       c.alu_op = ALU_SRL;
          JR: begin
            c.reg_wr = 1'b0;
            c.pc_src = PC_JR;
          end
          default:   c.reg_wr = 1'b0;
        endcase
      end
      ADDI, ADDIU: begin
        c.reg_wr  = 1'b1;
        c.alu_src = 1'b1;
        c.ext_op  = 1'b1;
      end
      SLTI, SLTIU: begin
        c.reg_wr  = 1'b1;
        c.alu_src = 1'b1;
        c.ext_op  = 1'b1;
        c.alu_op  = (w[31:26] == SLTI) ? ALU_SLT : ALU_SLTU;
      end
      ANDI, ORI, XORI: begin
        c.reg_wr  = 1'b1;
        c.alu_src = 1'b1;
        c.alu_op  = (w[31:26] == ANDI) ? ALU_AND : (w[31:26] == ORI) ? ALU_OR : ALU_XOR;
      end
      LUI: begin
        c.reg_wr   = 1'b1;
        c.alu_src  = 1'b1;
        c.shift_up = 1'b1;
      end
      LW: begin
        c.reg_wr     = 1'b1;
        c.alu_src    = 1'b1;
        c.ext_op     = 1'b1;
        c.mem_to_reg = 1'b1;
        c.mem_rd     = 1'b1;
      end
      SW: begin
        c.alu_src = 1'b1;
        c.ext_op  = 1'b1;
        c.mem_wr  = 1'b1;
      end
      BEQ, BNE: begin
        c.ext_op = 1'b1;
        c.alu_op = ALU_SUB;
        c.pc_src = (w[31:26] == BEQ) ? PC_BEQ : PC_BNE;
      end
      J: c.pc_src = PC_JUMP;
      JAL: begin
        c.reg_wr  = 1'b1;
        c.wr_link = 1'b1;
        c.pc_src  = PC_JUMP;
      end
      HALT: c.halt = 1'b1;
      default: ;
    endcase
    return c;
  endfunction

  // Read with same-cycle write bypass
  function automatic word_t shadow_read(logic [4:0] sel);
    if (sel == 5'd0)
      return '0;
    if (wb.wen && wb.wsel == sel)
      return wb.wdat;
    return shadow[sel];
  endfunction

  always_comb begin
    pred.ctrl     = expect_ctrl(s1.instr);
    pred.wsel     = pred.ctrl.wr_link ? 5'd31 :
                    pred.ctrl.reg_dst ? s1.instr[15:11] : s1.instr[20:16];
    pred.rdat1    = shadow_read(s1.instr[25:21]);
    pred.rdat2    = shadow_read(s1.instr[20:16]);
    if (pred.ctrl.shift_up)
      pred.ext_out = {s1.instr[15:0], 16'h0000};
    else if (pred.ctrl.ext_op)
      pred.ext_out = {{16{s1.instr[15]}}, s1.instr[15:0]};
    else
      pred.ext_out = {16'h0000, s1.instr[15:0]};
    pred.shamt    = s1.instr[10:6];
    pred.j_offset = s1.instr[25:0];
    pred.rs       = s1.instr[25:21];
    pred.rt       = s1.instr[20:16];
    pred.pc       = s1.pc;
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        shadow[i] <= '0;
      end
    end else if (wb.wen && wb.wsel != 5'd0) begin
      shadow[wb.wsel] <= wb.wdat;
    end
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      s1_valid  <= 1'b0;
      exp_valid <= 1'b0;
    end else begin
      if (!stall)
        s1_valid <= fetch_valid;
      if (flush)
        exp_valid <= 1'b0;
      else if (!stall)
        exp_valid <= s1_valid;
    end
    if (!stall) begin
      s1      <= fetch;
      exp_pkt <= pred;
    end
  end

  valid_match: assert property (@(posedge CLK) disable iff (rst) dec_valid == exp_valid)
    else begin
      fail_count++;
      $error("dec_valid differs from the two-cycle model");
    end
  pc_match: assert property (@(posedge CLK) disable iff (rst) dec_valid |-> dec.pc == exp_pkt.pc)
    else begin
      fail_count++;
      $error("dec.pc wrong");
    end
  ctrl_match: assert property (@(posedge CLK) disable iff (rst)
    dec_valid |-> dec.ctrl == exp_pkt.ctrl)
    else begin
      fail_count++;
      $error("control fields wrong");
    end
  wsel_match: assert property (@(posedge CLK) disable iff (rst)
    dec_valid |-> dec.wsel == exp_pkt.wsel)
    else begin
      fail_count++;
      $error("wsel wrong");
    end
  operand_match: assert property (@(posedge CLK) disable iff (rst)
    dec_valid |-> dec.rdat1 == exp_pkt.rdat1 && dec.rdat2 == exp_pkt.rdat2)
    else begin
      fail_count++;
      $error("register read data wrong");
    end
  field_match: assert property (@(posedge CLK) disable iff (rst)
    dec_valid |-> dec.ext_out == exp_pkt.ext_out && dec.j_offset == exp_pkt.j_offset &&
                  dec.shamt == exp_pkt.shamt && dec.rs == exp_pkt.rs && dec.rt == exp_pkt.rt)
    else begin
      fail_count++;
      $error("immediate or field passthrough wrong");
    end
  stall_hold: assert property (@(posedge CLK) disable iff (rst)
    stall && !flush |=> $stable(dec_valid))
    else begin
      fail_count++;
      $error("dec_valid changed under stall");
    end
  stall_data: assert property (@(posedge CLK) disable iff (rst)
    stall && dec_valid |=> $stable(dec))
    else begin
      fail_count++;
      $error("dec changed under stall");
    end
  flush_kill: assert property (@(posedge CLK) disable iff (rst) flush |=> !dec_valid)
    else begin
      fail_count++;
      $error("dec_valid survived a flush");
    end

endmodule

// ==== decode_top.sv ====
// Top level of the decode slice: fetch latch, decode stage and decode/execute latch
module decode_top import cpu_types_pkg::*; (
  input  logic        CLK,
  input  logic        rst,
  input  logic        fetch_valid,
  input  fetch_pkt_t  fetch,
  input  logic        stall,
  input  logic        flush,
  input  wb_t         wb,
  output logic        dec_valid,
  output decode_pkt_t dec
);

  fetch_pkt_t  fd_data;
  logic        fd_valid;
  decode_pkt_t de_data;

  // Flush only kills the decode boundary
  pipe_latch #(
    .payload_t (fetch_pkt_t)
  ) fd_latch0 (
    .CLK       (CLK),
    .rst       (rst),
    .stall     (stall),
    .flush     (1'b0),
    .in_valid  (fetch_valid),
    .in_data   (fetch),
    .out_valid (fd_valid),
    .out_data  (fd_data)
  );

  decode_stage ds0 (
    .CLK   (CLK),
    .rst   (rst),
    .fetch (fd_data),
    .wb    (wb),
    .dec   (de_data)
  );

  pipe_latch #(
    .payload_t (decode_pkt_t)
  ) de_latch0 (
    .CLK       (CLK),
    .rst       (rst),
    .stall     (stall),
    .flush     (flush),
    .in_valid  (fd_valid),
    .in_data   (de_data),
    .out_valid (dec_valid),
    .out_data  (dec)
  );

endmodule

// ==== decode_stage.sv ====
// Decode stage: control unit and register file in parallel, immediate extend, packet build
module decode_stage import cpu_types_pkg::*; (
  input  logic        CLK,
  input  logic        rst,
  input  fetch_pkt_t  fetch,
  input  wb_t         wb,
  output decode_pkt_t dec
);

  r_t       rinstr;
  i_t       iinstr;
  j_t       jinstr;
  ctrl_t    ctrl;
  word_t    rdat1;
  word_t    rdat2;
  word_t    ext_out;
  regbits_t wsel;

  // Three views of the same instruction word
  always_comb begin
    rinstr = fetch.instr;
    iinstr = fetch.instr;
    jinstr = fetch.instr;
  end

  control_unit cu0 (
    .instr (fetch.instr),
    .ctrl  (ctrl)
  );

  register_file rf0 (
    .CLK   (CLK),
    .rst   (rst),
    .rsel1 (rinstr.rs),
    .rsel2 (rinstr.rt),
    .wb    (wb),
    .rdat1 (rdat1),
    .rdat2 (rdat2)
  );

  // Zero extend unless lui or a signed-immediate op
  always_comb begin
    ext_out = {{(WORD_W-IMM_W){1'b0}}, iinstr.imm};
    if (ctrl.shift_up)
      ext_out = {iinstr.imm, {(WORD_W-IMM_W){1'b0}}};
    else if (ctrl.ext_op)
      ext_out = {{(WORD_W-IMM_W){iinstr.imm[IMM_W-1]}}, iinstr.imm};
  end

  // Destination: link register, then rd, then rt
  always_comb begin
    if (ctrl.wr_link)
      wsel = LINK_REG;
    else if (ctrl.reg_dst)
      wsel = rinstr.rd;
    else
      wsel = rinstr.rt;
  end

  always_comb begin
    dec.ctrl     = ctrl;
    dec.wsel     = wsel;
    dec.rdat1    = rdat1;
    dec.rdat2    = rdat2;
    dec.ext_out  = ext_out;
    dec.shamt    = rinstr.shamt;
    dec.j_offset = jinstr.addr;
    dec.rs       = rinstr.rs;
    dec.rt       = rinstr.rt;
    dec.pc       = fetch.pc;
  end

endmodule

// ==== pipe_latch.sv ====
// Generic stage boundary register with valid bit, stall hold and flush, payload set by type
module pipe_latch #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     CLK,
  input  logic     rst,
  input  logic     stall,
  input  logic     flush,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     out_valid,
  output payload_t out_data
);

  // Flush beats stall so a killed slot never survives a hold
  always_ff @(posedge CLK) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (flush) begin
      out_valid <= 1'b0;
    end else if (!stall) begin
      out_valid <= in_valid;
    end
  end

  // Payload only qualified by out_valid
  always_ff @(posedge CLK) begin
    if (!stall) begin
      out_data <= in_data;
    end
  end

endmodule

// ==== register_file.sv ====
// 32x32 register file with two bypassed read ports and one write port, $zero hardwired
module register_file import cpu_types_pkg::*; (
  input  logic     CLK,
  input  logic     rst,
  input  regbits_t rsel1,
  input  regbits_t rsel2,
  input  wb_t      wb,
  output word_t    rdat1,
  output word_t    rdat2
);

  // Register 0 has no storage
  word_t regs [1:2**REG_W-1];

  always_ff @(posedge CLK) begin
    if (rst) begin
      for (int i = 1; i < 2**REG_W; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.wen && wb.wsel != '0) begin
      regs[wb.wsel] <= wb.wdat;
    end
  end

  // Same-cycle write wins over the stored value
  function automatic word_t read_port(regbits_t sel);
    word_t val;
    if (sel == '0)
      val = '0;
    else if (wb.wen && wb.wsel == sel)
      val = wb.wdat;
    else
      val = regs[sel];
    return val;
  endfunction

  always_comb begin
    rdat1 = read_port(rsel1);
    rdat2 = read_port(rsel2);
  end

endmodule

// ==== control_unit.sv ====
// Combinational main decoder turning opcode and funct into the control struct of decode
module control_unit import cpu_types_pkg::*; (
  input  word_t instr,
  output ctrl_t ctrl
);

  r_t rinstr;

  assign rinstr = instr;

  always_comb begin
    // Safe default: no register write, no memory access, sequential PC
    ctrl        = '0;
    ctrl.alu_op = ALU_ADD;
    ctrl.pc_src = PC_SEQ;

    case (rinstr.opcode)
      RTYPE: begin
        ctrl.reg_wr  = 1'b1;
        ctrl.reg_dst = 1'b1;
        case (rinstr.funct)
          ADD, ADDU: ctrl.alu_op = ALU_ADD;
          SUB, SUBU: ctrl.alu_op = ALU_SUB;
          AND:       ctrl.alu_op = ALU_AND;
          OR:        ctrl.alu_op = ALU_OR;
          XOR:       ctrl.alu_op = ALU_XOR;
          NOR:       ctrl.alu_op = ALU_NOR;
          SLT:       ctrl.alu_op = ALU_SLT;
          SLTU:      ctrl.alu_op = ALU_SLTU;
          SLL:       ctrl.alu_op = ALU_SLL;
          SRL:       ctrl.alu_op = ALU_SRL;
          JR: begin
            ctrl.reg_wr = 1'b0;
            ctrl.pc_src = PC_JR;
          end
          // Unknown funct writes nothing
          default:   ctrl.reg_wr = 1'b0;
        endcase
      end

      ADDI, ADDIU: begin
        ctrl.reg_wr  = 1'b1;
        ctrl.alu_src = 1'b1;
        ctrl.ext_op  = 1'b1;
      end

      SLTI, SLTIU: begin
        ctrl.reg_wr  = 1'b1;
        ctrl.alu_src = 1'b1;
        ctrl.ext_op  = 1'b1;
        ctrl.alu_op  = (rinstr.opcode == SLTI) ? ALU_SLT : ALU_SLTU;
      end

      // Logical immediates are zero-extended
      ANDI, ORI, XORI: begin
        ctrl.reg_wr  = 1'b1;
        ctrl.alu_src = 1'b1;
        case (rinstr.opcode)
          ANDI:    ctrl.alu_op = ALU_AND;
          ORI:     ctrl.alu_op = ALU_OR;
          default: ctrl.alu_op = ALU_XOR;
        endcase
      end

      // rs is $zero in lui, so an add passes the shifted immediate
      LUI: begin
        ctrl.reg_wr   = 1'b1;
        ctrl.alu_src  = 1'b1;
        ctrl.shift_up = 1'b1;
      end

      LW: begin
        ctrl.reg_wr     = 1'b1;
        ctrl.alu_src    = 1'b1;
        ctrl.ext_op     = 1'b1;
        ctrl.mem_to_reg = 1'b1;
        ctrl.mem_rd     = 1'b1;
      end

      SW: begin
        ctrl.alu_src = 1'b1;
        ctrl.ext_op  = 1'b1;
        ctrl.mem_wr  = 1'b1;
      end

      BEQ, BNE: begin
        ctrl.ext_op = 1'b1;
        ctrl.alu_op = ALU_SUB;
        ctrl.pc_src = (rinstr.opcode == BEQ) ? PC_BEQ : PC_BNE;
      end

      J:    ctrl.pc_src = PC_JUMP;

      JAL: begin
        ctrl.reg_wr  = 1'b1;
        ctrl.wr_link = 1'b1;
        ctrl.pc_src  = PC_JUMP;
      end

      HALT: ctrl.halt = 1'b1;

      default: ;
    endcase
  end

endmodule

// ==== cpu_types_pkg.sv ====
// Widths, MIPS encodings and pipeline packet types shared by every decode-side module
package cpu_types_pkg;

  localparam int WORD_W  = 32;
  localparam int REG_W   = 5;
  localparam int IMM_W   = 16;
  localparam int ADDR_W  = 26;
  localparam int OP_W    = 6;
  localparam int FUNC_W  = 6;
  localparam int SHAMT_W = 5;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [REG_W-1:0]  regbits_t;

  // jal writes its return address here
  localparam regbits_t LINK_REG = 5'd31;

  // Standard MIPS opcode field values, halt takes the all-ones slot
  typedef enum logic [OP_W-1:0] {
    RTYPE = 6'h00,
    J     = 6'h02,
    JAL   = 6'h03,
    BEQ   = 6'h04,
    BNE   = 6'h05,
    ADDI  = 6'h08,
    ADDIU = 6'h09,
    SLTI  = 6'h0a,
    SLTIU = 6'h0b,
    ANDI  = 6'h0c,
    ORI   = 6'h0d,
    XORI  = 6'h0e,
    LUI   = 6'h0f,
    LW    = 6'h23,
    SW    = 6'h2b,
    HALT  = 6'h3f
  } opcode_t;

  // R-type function field
  typedef enum logic [FUNC_W-1:0] {
    SLL  = 6'h00,
    SRL  = 6'h02,
    JR   = 6'h08,
    ADD  = 6'h20,
    ADDU = 6'h21,
    SUB  = 6'h22,
    SUBU = 6'h23,
    AND  = 6'h24,
    OR   = 6'h25,
    XOR  = 6'h26,
    NOR  = 6'h27,
    SLT  = 6'h2a,
    SLTU = 6'h2b
  } funct_t;

  typedef enum logic [3:0] {
    ALU_SLL,   // shift left by shamt
    ALU_SRL,   // logical shift right
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_NOR,
    ALU_SLT,   // signed compare
    ALU_SLTU   // unsigned compare
  } aluop_t;

  // Five sources, so three bits
  typedef enum logic [2:0] {
    PC_SEQ,
    PC_BEQ,
    PC_BNE,
    PC_JUMP,
    PC_JR
  } pcsrc_t;

  // Field overlays of one instruction word
  typedef struct packed {
    opcode_t              opcode;
    regbits_t             rs;
    regbits_t             rt;
    regbits_t             rd;
    logic [SHAMT_W-1:0]   shamt;
    funct_t               funct;
  } r_t;

  typedef struct packed {
    opcode_t              opcode;
    regbits_t             rs;
    regbits_t             rt;
    logic [IMM_W-1:0]     imm;
  } i_t;

  typedef struct packed {
    opcode_t              opcode;
    logic [ADDR_W-1:0]    addr;
  } j_t;

  typedef struct packed {
    logic    reg_wr;
    logic    reg_dst;
    logic    wr_link;
    logic    ext_op;
    logic    shift_up;
    logic    mem_to_reg;
    logic    mem_rd;
    logic    mem_wr;
    logic    alu_src;
    aluop_t  alu_op;
    pcsrc_t  pc_src;
    logic    halt;
  } ctrl_t;

  typedef struct packed {
    word_t instr;
    word_t pc;
  } fetch_pkt_t;

  typedef struct packed {
    ctrl_t               ctrl;
    regbits_t            wsel;
    word_t               rdat1;
    word_t               rdat2;
    word_t               ext_out;
    logic [SHAMT_W-1:0]  shamt;
    logic [ADDR_W-1:0]   j_offset;
    regbits_t            rs;
    regbits_t            rt;
    word_t               pc;
  } decode_pkt_t;

  // Write-back request from the later stages
  typedef struct packed {
    logic     wen;
    regbits_t wsel;
    word_t    wdat;
  } wb_t;

endpackage
